// File: include/pma_params.svh
`ifndef PMA_PARAMS_SVH
`define PMA_PARAMS_SVH

// Physical address width of the load/store unit
`define PMA_PADDR_W 56

// Request tag width, echoed back in the response
`define PMA_TAG_W 4

// Default depth of the checked-request FIFO (power of two)
`define PMA_FIFO_DEPTH 4

// Entries in the fixed region table
`define PMA_REGIONS 11

`endif

// File: rtl/pma_pkg.sv
`include "pma_params.svh"

package pma_pkg;

  typedef enum logic [1:0] {
    ACC_LOAD   = 2'd0,
    ACC_STORE  = 2'd1,
    ACC_FETCH  = 2'd2,
    ACC_ATOMIC = 2'd3
  } access_kind_e;

  // Access size, 1 << size bytes
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'd0,
    SIZE_HALF   = 2'd1,
    SIZE_WORD   = 2'd2,
    SIZE_DOUBLE = 2'd3
  } access_size_e;

  typedef enum logic [1:0] {
    PMA_OK           = 2'd0,
    PMA_MISALIGNED   = 2'd1,
    PMA_ACCESS_FAULT = 2'd2,
    PMA_NO_REGION    = 2'd3
  } pma_status_e;

  typedef struct packed {
    logic r;                               // Readable
    logic w;                               // Writable
    logic x;                               // Executable
    logic a;                               // Atomics allowed
    logic c;                               // Cacheable
  } map_attr_t;

  typedef struct packed {
    logic [`PMA_PADDR_W-1:0] paddr;
    access_kind_e            kind;
    access_size_e            size;
    logic [`PMA_TAG_W-1:0]   tag;
  } pma_req_t;

  // Request after the region lookup
  typedef struct packed {
    pma_req_t  req;
    logic      hit;
    map_attr_t attr;
  } pma_chk_t;

  typedef struct packed {
    logic [`PMA_TAG_W-1:0] tag;
    pma_status_e           status;
    logic                  cacheable;
  } pma_rsp_t;

endpackage

// File: rtl/pma_map.sv
`include "pma_params.svh"

module pma_map (
  input  logic [`PMA_PADDR_W-1:0] i_pa,
  output logic                    o_map_hit,
  output pma_pkg::map_attr_t      o_map_attr
);

  import pma_pkg::*;

  localparam int NUM_REGIONS = `PMA_REGIONS;

  // A region hits when the masked address equals its base
  localparam logic [`PMA_PADDR_W-1:0] REGION_MASK [NUM_REGIONS] = '{
    56'hff_ffff_ffff_f000,                 // 0x0 - 0xfff
    56'hff_ffff_ffff_f000,                 // 0x2000 - 0x2fff
    56'hff_ffff_ffff_f000,                 // 0x4000 - 0x4fff
    56'hff_ffff_ffff_0000,                 // 0x10000 - 0x1ffff
    56'hff_ffff_ffff_0000,                 // 0x20000 - 0x2ffff
    56'hff_ffff_ffff_0000,                 // 0x2000000 - 0x200ffff
    56'hff_ffff_ffff_f000,                 // 0x2010000 - 0x2010fff
    56'hff_ffff_fc00_0000,                 // 0xc000000 - 0xfffffff
    56'hff_ffff_ffff_f000,                 // 0x10000000 - 0x10000fff
    56'hff_ffff_ffff_f000,                 // 0x54000000 - 0x54000fff
    56'hff_ffff_f000_0000                  // 0x80000000 - 0x8fffffff
  };

  localparam logic [`PMA_PADDR_W-1:0] REGION_BASE [NUM_REGIONS] = '{
    56'h00_0000_0000_0000,
    56'h00_0000_0000_2000,
    56'h00_0000_0000_4000,
    56'h00_0000_0001_0000,
    56'h00_0000_0002_0000,
    56'h00_0000_0200_0000,
    56'h00_0000_0201_0000,
    56'h00_0000_0c00_0000,
    56'h00_0000_1000_0000,
    56'h00_0000_5400_0000,
    56'h00_0000_8000_0000
  };

  // Bit order r w x a c
  localparam map_attr_t REGION_ATTR [NUM_REGIONS] = '{
    5'b11110,                              // Boot ROM/RAM
    5'b11110,
    5'b11010,                              // No fetch
    5'b10100,                              // Read-only code
    5'b10101,                              // Cached read-only code
    5'b11011,
    5'b11010,
    5'b11010,
    5'b11111,
    5'b11010,                              // Device window
    5'b11111                               // Main memory
  };

  logic [NUM_REGIONS-1:0] w_hit_vec;
  map_attr_t              w_attr;

  for (genvar g = 0; g < NUM_REGIONS; g++) begin : g_region
    assign w_hit_vec[g] = (i_pa & REGION_MASK[g]) == REGION_BASE[g];
  end

  // Regions are disjoint, so at most one entry contributes
  always_comb begin
    w_attr = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (w_hit_vec[i]) begin
        w_attr = REGION_ATTR[i];
      end
    end
  end

  assign o_map_hit  = |w_hit_vec;
  assign o_map_attr = w_attr;

  // The table ranges must never overlap
  always_comb begin
    if (!$isunknown(i_pa)) begin
      assert ($onehot0(w_hit_vec))
        else $error("pma_map: overlapping regions hit %b for %h", w_hit_vec, i_pa);
    end
  end

endmodule

// File: rtl/pma_req_stage.sv
module pma_req_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_req_valid,
  input  pma_pkg::pma_req_t i_req,
  output logic              o_req_ready,
  output logic              o_chk_valid,
  output pma_pkg::pma_chk_t o_chk,
  input  logic              i_chk_ready
);

  import pma_pkg::*;

  logic      r_valid;
  pma_req_t  r_req;
  logic      w_accept;
  logic      w_map_hit;
  map_attr_t w_map_attr;

  // Ready when empty or draining this cycle
  assign o_req_ready = !r_valid || i_chk_ready;
  assign w_accept    = i_req_valid && o_req_ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_valid <= 1'b0;
    end else if (w_accept) begin
      r_valid <= 1'b1;
    end else if (i_chk_ready) begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_req <= i_req;
    end
  end

  // Lookup runs on the registered address
  pma_map i_pma_map (
    .i_pa       (r_req.paddr),
    .o_map_hit  (w_map_hit),
    .o_map_attr (w_map_attr)
  );

  assign o_chk_valid = r_valid;
  assign o_chk       = '{req: r_req, hit: w_map_hit, attr: w_map_attr};

  // Held output must not change, lookup result included
  a_chk_stable : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_chk_valid && !i_chk_ready |=> o_chk_valid && $stable(o_chk)
  ) else $error("pma_req_stage: output changed under back-pressure");

endmodule

// File: rtl/pma_req_fifo.sv
`include "pma_params.svh"

module pma_req_fifo #(
  parameter int DEPTH = `PMA_FIFO_DEPTH    // Power of two, at least 2
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_wr_valid,
  input  pma_pkg::pma_chk_t i_wr_data,
  output logic              o_wr_ready,
  output logic              o_rd_valid,
  output pma_pkg::pma_chk_t o_rd_data,
  input  logic              i_rd_ready
);

  import pma_pkg::*;

  localparam int              PTR_W      = $clog2(DEPTH);
  localparam logic [PTR_W:0]  FULL_COUNT = (PTR_W + 1)'(DEPTH);

  pma_chk_t         r_mem [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [PTR_W:0]   r_count;
  logic             w_push;
  logic             w_pop;

  assign o_wr_ready = r_count != FULL_COUNT;
  assign o_rd_valid = r_count != '0;
  assign o_rd_data  = r_mem[r_rd_ptr];      // Show-ahead head entry

  assign w_push = i_wr_valid && o_wr_ready;
  assign w_pop  = o_rd_valid && i_rd_ready;

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_mem[r_wr_ptr] <= i_wr_data;
    end
  end

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;       // Idle or push and pop together
      endcase
    end
  end

  a_no_write_full : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    r_count == FULL_COUNT && !w_pop |=> r_count == FULL_COUNT && $stable(r_wr_ptr)
  ) else $error("pma_req_fifo: write while full");

  a_no_read_empty : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    r_count == '0 |=> $stable(r_rd_ptr)
  ) else $error("pma_req_fifo: read while empty");

endmodule

// File: rtl/pma_access_judge.sv
module pma_access_judge (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_chk_valid,
  input  pma_pkg::pma_chk_t i_chk,
  output logic              o_chk_ready,
  output logic              o_rsp_valid,
  output pma_pkg::pma_rsp_t o_rsp,
  input  logic              i_rsp_ready
);

  import pma_pkg::*;

  logic        w_misaligned;
  logic        w_perm_ok;
  logic        w_pop;
  pma_status_e w_status;
  pma_rsp_t    w_rsp;
  logic        r_rsp_valid;
  pma_rsp_t    r_rsp;

  // Low address bits must be zero for the access size
  always_comb begin
    case (i_chk.req.size)
      SIZE_BYTE:   w_misaligned = 1'b0;
      SIZE_HALF:   w_misaligned = i_chk.req.paddr[0];
      SIZE_WORD:   w_misaligned = |i_chk.req.paddr[1:0];
      SIZE_DOUBLE: w_misaligned = |i_chk.req.paddr[2:0];
      default:     w_misaligned = 1'b1;
    endcase
  end

  always_comb begin
    case (i_chk.req.kind)
      ACC_LOAD:   w_perm_ok = i_chk.attr.r;
      ACC_STORE:  w_perm_ok = i_chk.attr.w;
      ACC_FETCH:  w_perm_ok = i_chk.attr.x;
      ACC_ATOMIC: w_perm_ok = i_chk.attr.r && i_chk.attr.w && i_chk.attr.a;
      default:    w_perm_ok = 1'b0;
    endcase
  end

  // First matching rule wins
  always_comb begin
    if (w_misaligned) begin
      w_status = PMA_MISALIGNED;
    end else if (!i_chk.hit) begin
      w_status = PMA_NO_REGION;
    end else if (!w_perm_ok) begin
      w_status = PMA_ACCESS_FAULT;
    end else begin
      w_status = PMA_OK;
    end
  end

  assign w_rsp = '{
    tag:       i_chk.req.tag,
    status:    w_status,
    cacheable: (w_status == PMA_OK) && i_chk.attr.c
  };

  assign o_chk_ready = !r_rsp_valid || i_rsp_ready;
  assign w_pop       = i_chk_valid && o_chk_ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_rsp_valid <= 1'b0;
    end else if (w_pop) begin
      r_rsp_valid <= 1'b1;
    end else if (i_rsp_ready) begin
      r_rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_pop) begin
      r_rsp <= w_rsp;
    end
  end

  assign o_rsp_valid = r_rsp_valid;
  assign o_rsp       = r_rsp;

endmodule

// File: rtl/pma_checker.sv
module pma_checker (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_req_valid,
  input  pma_pkg::pma_req_t i_req,
  output logic              o_req_ready,
  output logic              o_rsp_valid,
  output pma_pkg::pma_rsp_t o_rsp,
  input  logic              i_rsp_ready
);

  import pma_pkg::*;

  logic     w_stage_valid;                 // Stage to FIFO
  pma_chk_t w_stage_chk;
  logic     w_stage_ready;

  logic     w_fifo_valid;                  // FIFO to judge
  pma_chk_t w_fifo_chk;
  logic     w_fifo_ready;

  pma_req_stage i_pma_req_stage (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_req_ready (o_req_ready),
    .o_chk_valid (w_stage_valid),
    .o_chk       (w_stage_chk),
    .i_chk_ready (w_stage_ready)
  );

  pma_req_fifo i_pma_req_fifo (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_valid (w_stage_valid),
    .i_wr_data  (w_stage_chk),
    .o_wr_ready (w_stage_ready),
    .o_rd_valid (w_fifo_valid),
    .o_rd_data  (w_fifo_chk),
    .i_rd_ready (w_fifo_ready)
  );

  pma_access_judge i_pma_access_judge (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_chk_valid (w_fifo_valid),
    .i_chk       (w_fifo_chk),
    .o_chk_ready (w_fifo_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .i_rsp_ready (i_rsp_ready)
  );

endmodule

// File: bench/tb_pma_checker.sv
`include "pma_params.svh"

module tb_pma_checker;
  timeunit 1ns;
  timeprecision 100ps;

  import pma_pkg::*;

  localparam int AW       = `PMA_PADDR_W;
  localparam int DEPTH    = `PMA_FIFO_DEPTH;
  localparam int NUM_REG  = `PMA_REGIONS;
  localparam int CLK_HALF = 20;
  // About 700 cycles of tests with random ready halving the drain rate
  localparam int MAX_CYCLES = 2000;

  typedef logic [AW-1:0] addr_t;
  typedef enum int {READY_LOW, READY_HIGH, READY_RANDOM} ready_mode_e;

  // Inclusive address ranges of the region table
  localparam addr_t REG_LO [NUM_REG] = '{
    56'h0, 56'h2000, 56'h4000, 56'h1_0000, 56'h2_0000, 56'h200_0000,
    56'h201_0000, 56'hc00_0000, 56'h1000_0000, 56'h5400_0000, 56'h8000_0000
  };
  localparam addr_t REG_HI [NUM_REG] = '{
    56'hfff, 56'h2fff, 56'h4fff, 56'h1_ffff, 56'h2_ffff, 56'h200_ffff,
    56'h201_0fff, 56'hfff_ffff, 56'h1000_0fff, 56'h5400_0fff, 56'h8fff_ffff
  };
  // Bits r w x a c
  localparam map_attr_t REG_ATTR [NUM_REG] = '{
    5'b11110, 5'b11110, 5'b11010, 5'b10100, 5'b10101, 5'b11011,
    5'b11010, 5'b11010, 5'b11111, 5'b11010, 5'b11111
  };

  logic     i_clk;
  logic     i_rst_n;
  logic     i_req_valid;
  pma_req_t i_req;
  logic     o_req_ready;
  logic     o_rsp_valid;
  pma_rsp_t o_rsp;
  logic     i_rsp_ready;

  pma_rsp_t              exp_q [$];        // Expected responses in arrival order
  int                    errors       = 0;
  int                    checks       = 0;
  int                    cycle_cnt    = 0;
  int                    accept_cycle = 0;
  int                    take_cycle   = 0;
  logic [`PMA_TAG_W-1:0] next_tag     = '0;
  ready_mode_e           ready_mode   = READY_HIGH;

  pma_checker i_pma_checker (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .i_rsp_ready (i_rsp_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever begin
      #CLK_HALF i_clk = ~i_clk;
    end
  end

  initial begin : cycle_limit
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge i_clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with %0d responses outstanding", cycle_cnt,
             exp_q.size());
    $display("Test failed");
    $finish;
  end

  // Response ready follows the mode picked at the previous edge
  initial begin : rsp_ready_drive
    ready_mode_e mode;
    i_rsp_ready = 1'b1;
    forever begin
      @(posedge i_clk);
      mode = ready_mode;
      #2;
      case (mode)
        READY_LOW:  i_rsp_ready = 1'b0;
        READY_HIGH: i_rsp_ready = 1'b1;
        default:    i_rsp_ready = 1'($urandom_range(0, 1));
      endcase
    end
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("Mismatch at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
      end
  endtask

  // Sampled mid-cycle since the transfer happens at the next rising edge
  always @(negedge i_clk) begin : rsp_monitor
    pma_rsp_t exp;
    if (i_rst_n && o_rsp_valid && i_rsp_ready) begin
      take_cycle = cycle_cnt + 1;
      checks++;
      assert (exp_q.size() != 0)
        else begin
          $display("Response with tag %0d at %0d ns arrived with no request outstanding",
                   o_rsp.tag, $time);
          errors++;
        end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        compare("o_rsp.tag", 64'(o_rsp.tag), 64'(exp.tag));
        compare("o_rsp.status", 64'(o_rsp.status), 64'(exp.status));
        compare("o_rsp.cacheable", 64'(o_rsp.cacheable), 64'(exp.cacheable));
      end
    end
  end

  // Judge rules applied to the region table
  function automatic pma_rsp_t model(input pma_req_t req);
    addr_t     nbytes;
    logic      hit;
    logic      allowed;
    map_attr_t attr;
    pma_rsp_t  rsp;
    nbytes = addr_t'(1) << req.size;
    hit    = 1'b0;
    attr   = '0;
    for (int i = 0; i < NUM_REG; i++) begin
      if (req.paddr >= REG_LO[i] && req.paddr <= REG_HI[i]) begin
        hit  = 1'b1;
        attr = REG_ATTR[i];
      end
    end
    case (req.kind)
      ACC_LOAD:  allowed = attr.r;
      ACC_STORE: allowed = attr.w;
      ACC_FETCH: allowed = attr.x;
      default:   allowed = attr.r && attr.w && attr.a;
    endcase
    rsp.tag = req.tag;
    if ((req.paddr % nbytes) != '0) begin
      rsp.status = PMA_MISALIGNED;
    end else if (!hit) begin
      rsp.status = PMA_NO_REGION;
    end else if (!allowed) begin
      rsp.status = PMA_ACCESS_FAULT;
    end else begin
      rsp.status = PMA_OK;
    end
    rsp.cacheable = (rsp.status == PMA_OK) && attr.c;
    return rsp;
  endfunction

  // Called 2 ns after a rising edge and returns at the same phase
  task automatic issue(input pma_req_t req, input pma_rsp_t exp);
    logic taken;
    taken       = 1'b0;
    i_req       = req;
    i_req_valid = 1'b1;
    while (!taken) begin
      @(negedge i_clk);
      if (o_req_ready) begin
        taken        = 1'b1;
        accept_cycle = cycle_cnt + 1;
        exp_q.push_back(exp);
      end
      @(posedge i_clk);
      #2;
    end
    i_req_valid = 1'b0;
    next_tag++;
  endtask

  task automatic send(input addr_t addr, input access_kind_e kind, input access_size_e size);
    pma_req_t req;
    req.paddr = addr;
    req.kind  = kind;
    req.size  = size;
    req.tag   = next_tag;
    issue(req, model(req));
  endtask

  // Request with a response fixed by the test
  task automatic probe(input addr_t addr, input access_kind_e kind, input access_size_e size,
                       input pma_status_e status, input logic cacheable);
    pma_req_t req;
    pma_rsp_t exp;
    req.paddr     = addr;
    req.kind      = kind;
    req.size      = size;
    req.tag       = next_tag;
    exp.tag       = next_tag;
    exp.status    = status;
    exp.cacheable = cacheable;
    issue(req, exp);
  endtask

  task automatic wait_drain();
    do begin
      @(posedge i_clk);
    end while (exp_q.size() != 0);
    #2;
  endtask

  task automatic report(input string name, input int err_before);
    $display("%s finished with %0d errors", name, errors - err_before);
  endtask

  // Mostly within 8 bytes of a region boundary
  function automatic addr_t rand_addr();
    int    region;
    int    offset;
    addr_t anchor;
    region = int'($urandom_range(0, NUM_REG - 1));
    offset = int'($urandom_range(0, 16)) - 8;
    anchor = $urandom_range(0, 1) ? REG_LO[region] : REG_HI[region] + addr_t'(1);
    if ($urandom_range(0, 7) == 0) begin
      return addr_t'($urandom);
    end else begin
      return anchor + addr_t'(offset);
    end
  endfunction

  task automatic reset_and_latency();
    int err0;
    err0 = errors;
    @(negedge i_clk);
    compare("o_rsp_valid", 64'(o_rsp_valid), 64'd0);
    compare("o_req_ready", 64'(o_req_ready), 64'd1);
    @(posedge i_clk);
    #2;
    probe(56'h8000_0000, ACC_LOAD, SIZE_DOUBLE, PMA_OK, 1'b1);
    wait_drain();
    compare("response latency", 64'(take_cycle - accept_cycle), 64'd3);
    report("reset_and_latency", err0);
  endtask

  task automatic kinds_vs_permissions();
    int err0;
    err0 = errors;
    probe(56'h1_0000, ACC_STORE, SIZE_WORD, PMA_ACCESS_FAULT, 1'b0);
    probe(56'h4000, ACC_FETCH, SIZE_WORD, PMA_ACCESS_FAULT, 1'b0);
    probe(56'h2_0000, ACC_ATOMIC, SIZE_WORD, PMA_ACCESS_FAULT, 1'b0);
    probe(56'h200_0000, ACC_ATOMIC, SIZE_DOUBLE, PMA_OK, 1'b1);
    probe(56'h1000_0000, ACC_FETCH, SIZE_WORD, PMA_OK, 1'b1);
    wait_drain();
    report("kinds_vs_permissions", err0);
  endtask

  task automatic unmapped_and_misaligned();
    int err0;
    err0 = errors;
    probe(56'h1000, ACC_LOAD, SIZE_BYTE, PMA_NO_REGION, 1'b0);
    probe(56'h9000_0000, ACC_STORE, SIZE_WORD, PMA_NO_REGION, 1'b0);
    probe(56'h1000, ACC_FETCH, SIZE_WORD, PMA_NO_REGION, 1'b0);
    probe(56'h8000_0004, ACC_LOAD, SIZE_DOUBLE, PMA_MISALIGNED, 1'b0);
    probe(56'h2_0002, ACC_FETCH, SIZE_DOUBLE, PMA_MISALIGNED, 1'b0);
    probe(56'h1004, ACC_LOAD, SIZE_DOUBLE, PMA_MISALIGNED, 1'b0);  // Alignment before region
    wait_drain();
    report("unmapped_and_misaligned", err0);
  endtask

  task automatic region_edges();
    int err0;
    err0 = errors;
    for (int i = 0; i < NUM_REG; i++) begin
      for (int k = 0; k < 4; k++) begin
        send(REG_LO[i], access_kind_e'(2'(k)), SIZE_BYTE);
        send(REG_HI[i], access_kind_e'(2'(k)), SIZE_BYTE);
      end
    end
    wait_drain();
    report("region_edges", err0);
  endtask

  task automatic back_pressure();
    int   err0;
    int   n;
    logic stalled;
    err0    = errors;
    n       = 0;
    stalled = 1'b0;
    ready_mode = READY_LOW;
    repeat (2) @(posedge i_clk);
    #2;
    while (!stalled && n <= DEPTH + 2) begin
      @(negedge i_clk);
      stalled = !o_req_ready;
      @(posedge i_clk);
      #2;
      if (!stalled) begin
        send(REG_LO[n] + addr_t'(8 * n), access_kind_e'(2'(n)), SIZE_WORD);
        n++;
      end
    end
    checks++;
    assert (stalled)
      else begin
        $display("o_req_ready did not drop within %0d accepted requests", n);
        errors++;
      end
    ready_mode = READY_HIGH;
    wait_drain();
    report("back_pressure", err0);
  endtask

  task automatic random_stream();
    int err0;
    err0 = errors;
    ready_mode = READY_RANDOM;
    repeat (200) begin
      send(rand_addr(), access_kind_e'(2'($urandom_range(0, 3))),
           access_size_e'(2'($urandom_range(0, 3))));
    end
    wait_drain();
    ready_mode = READY_HIGH;
    report("random_stream", err0);
  endtask

  initial begin
    void'($urandom(32'he017_bead));
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req       = '0;
    repeat (4) @(posedge i_clk);
    #2;
    i_rst_n = 1'b1;
    reset_and_latency();
    kinds_vs_permissions();
    unmapped_and_misaligned();
    region_edges();
    back_pressure();
    random_stream();
    $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+include
rtl/pma_pkg.sv
rtl/pma_map.sv
rtl/pma_req_stage.sv
rtl/pma_req_fifo.sv
rtl/pma_access_judge.sv
rtl/pma_checker.sv
bench/tb_pma_checker.sv

// File: Makefile
SIM  := obj_dir/Vtb_pma_checker
SRCS := $(shell grep -v '^+' files.f) include/pma_params.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) files.f
	verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
		--top-module tb_pma_checker -f files.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Test completed successfully" sim.log
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log
